/* flist.f */
design/snac_pkg.sv
design/db15_reader.sv
design/control_mapper.sv
design/rotary_tracker.sv
design/dip_bank.sv
design/input_top.sv
tests/input_checker.sv
tests/tb_input_top.sv

/* Makefile */
# Verilator flow for the player-input front end

VERILATOR ?= verilator
TOP       ?= tb_input_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
PASS_STR  ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# The log decides the result, whatever the simulator exit status was
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_input_top.sv */
// Runs four cfg phases with random host and pad words; the bound checker does most checking
`timescale 1ns/1ps

module tb_input_top;

	localparam int JOY_DIV     = 2;
	localparam int ROT_STEP    = 64;
	localparam int FRAME_LIMIT = 400;

	logic                   clk_53p6;
	logic                   rst;
	logic                   joy_data;
	snac_pkg::host_joy_t    host_joy0;
	snac_pkg::host_joy_t    host_joy1;
	snac_pkg::snac_cfg_t    cfg;
	logic                   ioctl_wr;
	logic [7:0]             ioctl_index;
	logic [24:0]            ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic                   joy_clk;
	logic                   joy_load;
	snac_pkg::player_word_t player1;
	snac_pkg::player_word_t player2;
	logic [7:0]             dsw1;
	logic [7:0]             dsw2;
	logic [7:0]             game;

	logic [31:0]         lfsr_state;
	logic [31:0]         dev_sr;
	snac_pkg::pad_word_t frame_p1;
	snac_pkg::pad_word_t frame_p2;
	logic                prev_jclk;
	logic                prev_load;

	input_top #(
		.JOY_DIV  (JOY_DIV),
		.ROT_STEP (ROT_STEP)
	) u_input_top (
		.clk_53p6    (clk_53p6),
		.rst         (rst),
		.joy_data    (joy_data),
		.host_joy0   (host_joy0),
		.host_joy1   (host_joy1),
		.cfg         (cfg),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.joy_clk     (joy_clk),
		.joy_load    (joy_load),
		.player1     (player1),
		.player2     (player2),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game        (game)
	);

	initial begin
		clk_53p6 = 1'b0;
		forever #20 clk_53p6 = ~clk_53p6;
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r          = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	// ============================
	// Pad device and host words
	// ============================

	always @(posedge clk_53p6) begin : pad_model
		snac_pkg::pad_word_t np1;
		snac_pkg::pad_word_t np2;
		if (!rst) begin
			host_joy0 <= next_bits(16);
			host_joy1 <= next_bits(16);
			// Frame end must carry the words shifted out
			if (u_input_top.pad_valid && u_input_top.pad1 !== frame_p1) begin
				$display("ERROR t=%0t pad1 exp=%h got=%h", $time, frame_p1, u_input_top.pad1);
				abort_run("pad 1 word differs from the serial model");
			end else if (u_input_top.pad_valid && u_input_top.pad2 !== frame_p2) begin
				$display("ERROR t=%0t pad2 exp=%h got=%h", $time, frame_p2, u_input_top.pad2);
				abort_run("pad 2 word differs from the serial model");
			end
			// Latch new buttons on load, shift on each falling joy_clk
			if (joy_load && !prev_load) begin
				np1      = next_bits(16);
				np2      = next_bits(16);
				frame_p1 <= np1;
				frame_p2 <= np2;
				dev_sr   <= {np1, np2};
				joy_data <= np1[15];
			end else if (prev_jclk && !joy_clk) begin
				dev_sr   <= {dev_sr[30:0], 1'b1};
				joy_data <= dev_sr[30];
			end
		end
		prev_jclk <= joy_clk;
		prev_load <= joy_load;
	end

	always @(posedge clk_53p6) begin
		if (u_input_top.u_input_checker.fail_cnt != 0) begin
			abort_run("an assertion in the checker failed");
		end
	end

	// ============================
	// Stimulus tasks
	// ============================

	task automatic wait_frames(input int n);
		int cnt;
		for (int i = 0; i < n; i++) begin
			cnt = 0;
			do begin
				@(negedge clk_53p6);
				cnt++;
			end while (!u_input_top.pad_valid && cnt < FRAME_LIMIT);
			if (cnt >= FRAME_LIMIT) begin
				abort_run("timeout waiting for pad_valid");
			end
		end
	endtask

	task automatic dip_write(input logic [7:0] idx, input logic [24:0] addr,
			input logic [7:0] data);
		@(posedge clk_53p6);
		ioctl_wr    <= 1'b1;
		ioctl_index <= idx;
		ioctl_addr  <= addr;
		ioctl_dout  <= data;
		@(posedge clk_53p6);
		ioctl_wr    <= 1'b0;
	endtask

	// Mix of DIP, game and foreign writes over addresses 0 to 3
	task automatic run_phase(input snac_pkg::snac_cfg_t c, input int seed);
		logic [7:0] idx_tab [4];
		idx_tab = '{8'd254, 8'd1, 8'd254, 8'd7};
		@(posedge clk_53p6);
		cfg <= c;
		wait_frames(5);
		for (int i = 0; i < 8; i++) begin
			dip_write(idx_tab[(i + seed) % 4], 25'(i % 4), 8'(8'h3c ^ (i * 37 + seed)));
		end
	endtask

	initial begin
		lfsr_state  = 32'h9a22_185f;
		rst         = 1'b1;
		joy_data    = 1'b1;
		host_joy0   = '0;
		host_joy1   = '0;
		cfg         = '0;
		ioctl_wr    = 1'b0;
		ioctl_index = '0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		dev_sr      = '1;
		frame_p1    = snac_pkg::PAD_IDLE;
		frame_p2    = snac_pkg::PAD_IDLE;
		prev_jclk   = 1'b0;
		prev_load   = 1'b0;
		repeat (8) @(posedge clk_53p6);
		rst <= 1'b0;

		// Host only, both pads, both LS-30, then mixed
		run_phase(4'b0000, 0);
		run_phase(4'b1100, 1);
		run_phase(4'b0011, 2);
		run_phase(4'b1001, 3);
		repeat (4) @(negedge clk_53p6);

		if (u_input_top.u_input_checker.fail_cnt != 0) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "checker reported errors");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

/* tests/input_checker.sv */
// Bound into input_top; rules are checked per cycle and held off during and just after reset
`timescale 1ns/1ps

module input_checker (
	input logic                   clk_53p6,
	input logic                   rst,
	input snac_pkg::snac_cfg_t    cfg,
	input snac_pkg::host_joy_t    host_joy0,
	input snac_pkg::host_joy_t    host_joy1,
	input logic                   joy_clk,
	input logic                   joy_load,
	input logic                   pad_valid,
	input snac_pkg::pad_word_t    pad1,
	input snac_pkg::pad_word_t    pad2,
	input snac_pkg::player_ctrl_t c1,
	input snac_pkg::player_ctrl_t c2,
	input snac_pkg::rot_pos_t     rot1,
	input snac_pkg::rot_pos_t     rot2,
	input snac_pkg::player_word_t player1,
	input snac_pkg::player_word_t player2,
	input logic                   ioctl_wr,
	input logic [7:0]             ioctl_index,
	input logic [24:0]            ioctl_addr,
	input logic [7:0]             ioctl_dout,
	input logic [7:0]             dsw1,
	input logic [7:0]             dsw2,
	input logic [7:0]             game
);

	// Read by the testbench to end the run
	int fail_cnt = 0;

	logic                   rst_q;
	logic                   hold;
	snac_pkg::player_word_t exp1, exp2, exp1_q, exp2_q;
	logic [2:0]             btn1, btn2, btn1_q, btn2_q;
	snac_pkg::rot_pos_t     prev_rot1, prev_rot2;
	snac_pkg::player_ctrl_t prev_c1, prev_c2;
	logic [1:0]             prev_ls;
	logic [3:0]             prev_code1, prev_code2, prev2_code1, prev2_code2;
	logic                   prev_wr;
	logic [7:0]             prev_index, prev_dout, prev_dsw1, prev_dsw2, prev_game;
	logic [24:0]            prev_addr;
	logic                   take1, take2;
	logic [7:0]             want_dsw1, want_dsw2, want_game;

	// ============================
	// Reference rules
	// ============================

	// Active-low packing from either the pad or the host word
	function automatic snac_pkg::player_word_t map_word(logic db, logic ls,
			snac_pkg::host_joy_t host, snac_pkg::pad_word_t pad, snac_pkg::rot_pos_t rot);
		logic [8:0] p;
		if (db || ls) begin
			// up down right left service missile shot start coin
			p[8] = ~pad[3];
			p[7] = ~pad[2];
			p[6] = ~pad[0];
			p[5] = ~pad[1];
			p[4] = ~pad[11] & ~pad[5];
			p[3] = db ? ~pad[6] : ~pad[5];
			p[2] = db ? ~pad[5] : ~pad[4];
			p[1] = ~pad[10];
			p[0] = ~pad[11];
		end else begin
			p[8] = host[3];
			p[7] = host[2];
			p[6] = host[0];
			p[5] = host[1];
			p[4] = host[10];
			p[3] = host[5];
			p[2] = host[4];
			p[1] = host[6];
			p[0] = host[7];
		end
		return {2'b11, ~p[8:4], 1'b1, rot, ~p[3:0]};
	endfunction

	// Pause, rot left and rot right, which the packed word does not carry
	function automatic logic [2:0] extra_btns(logic use_pad, snac_pkg::host_joy_t host,
			snac_pkg::pad_word_t pad);
		if (use_pad) begin
			return {~pad[4] & ~pad[11], ~pad[4], ~pad[7]};
		end
		return {host[11], host[8], host[9]};
	endfunction

	function automatic snac_pkg::rot_pos_t rot_inc(snac_pkg::rot_pos_t r);
		return (r == 4'd11) ? 4'd0 : r + 4'd1;
	endfunction

	function automatic snac_pkg::rot_pos_t rot_dec(snac_pkg::rot_pos_t r);
		return (r == 4'd0) ? 4'd11 : r - 4'd1;
	endfunction

	assign exp1 = map_word(cfg.db15_en[0], cfg.ls30_en[0], host_joy0, pad1, rot1);
	assign exp2 = map_word(cfg.db15_en[1], cfg.ls30_en[1], host_joy1, pad2, rot2);
	assign btn1 = extra_btns(cfg.db15_en[0] | cfg.ls30_en[0], host_joy0, pad1);
	assign btn2 = extra_btns(cfg.db15_en[1] | cfg.ls30_en[1], host_joy1, pad2);
	assign hold = rst | rst_q;

	// LS-30 follower takes a fresh code below 12
	assign take1 = prev_code1 != prev2_code1 && prev_code1 < 4'd12;
	assign take2 = prev_code2 != prev2_code2 && prev_code2 < 4'd12;

	assign want_dsw1 = (prev_wr && prev_index == 8'd254 && prev_addr == 25'd0) ?
		prev_dout : prev_dsw1;
	assign want_dsw2 = (prev_wr && prev_index == 8'd254 && prev_addr == 25'd1) ?
		prev_dout : prev_dsw2;
	assign want_game = (prev_wr && prev_index == 8'd1 && prev_addr == 25'd0) ?
		prev_dout : prev_game;

	// Last-cycle copies
	always_ff @(posedge clk_53p6) begin
		rst_q       <= rst;
		exp1_q      <= exp1;
		exp2_q      <= exp2;
		btn1_q      <= btn1;
		btn2_q      <= btn2;
		prev_rot1   <= rot1;
		prev_rot2   <= rot2;
		prev_c1     <= c1;
		prev_c2     <= c2;
		prev_ls     <= cfg.ls30_en;
		prev_code1  <= pad1[9:6];
		prev_code2  <= pad2[9:6];
		prev2_code1 <= prev_code1;
		prev2_code2 <= prev_code2;
		prev_wr     <= ioctl_wr;
		prev_index  <= ioctl_index;
		prev_addr   <= ioctl_addr;
		prev_dout   <= ioctl_dout;
		prev_dsw1   <= dsw1;
		prev_dsw2   <= dsw2;
		prev_game   <= game;
	end

	// ============================
	// Assertions
	// ============================

	a_reset: assert property (@(posedge clk_53p6) rst_q |-> !joy_clk && !joy_load &&
		!pad_valid && pad1 == snac_pkg::PAD_IDLE && pad2 == snac_pkg::PAD_IDLE)
		else begin
			$error("ERROR t=%0t joy_clk/joy_load/pad1 exp=0/0/ffff got=%b/%b/%h",
				$time, joy_clk, joy_load, pad1);
			fail_cnt++;
		end

	// Player 1 starts at 11, player 2 at 0
	a_rot_reset: assert property (@(posedge clk_53p6) rst_q |-> rot1 == 4'd11 && rot2 == 4'd0)
		else begin
			$error("ERROR t=%0t rot1/rot2 exp=11/0 got=%0d/%0d", $time, rot1, rot2);
			fail_cnt++;
		end

	a_word1: assert property (@(posedge clk_53p6) disable iff (hold) player1 == exp1_q)
		else begin
			$error("ERROR t=%0t player1 exp=%h got=%h", $time, exp1_q, player1);
			fail_cnt++;
		end

	a_word2: assert property (@(posedge clk_53p6) disable iff (hold) player2 == exp2_q)
		else begin
			$error("ERROR t=%0t player2 exp=%h got=%h", $time, exp2_q, player2);
			fail_cnt++;
		end

	// Buttons that only reach the rotary side
	a_ctrl: assert property (@(posedge clk_53p6) disable iff (hold)
		{c1.pause, c1.rot_left, c1.rot_right} == btn1_q &&
		{c2.pause, c2.rot_left, c2.rot_right} == btn2_q)
		else begin
			$error("ERROR t=%0t c1/c2 pause,rot_left,rot_right exp=%b/%b got=%b/%b", $time,
				btn1_q, btn2_q, {c1.pause, c1.rot_left, c1.rot_right},
				{c2.pause, c2.rot_left, c2.rot_right});
			fail_cnt++;
		end

	// One step at most, in the held direction
	a_rot1: assert property (@(posedge clk_53p6) disable iff (hold)
		(!cfg.ls30_en[0] && !prev_ls[0]) |-> rot1 == prev_rot1 ||
		(prev_c1.rot_left && rot1 == rot_inc(prev_rot1)) ||
		(!prev_c1.rot_left && prev_c1.rot_right && rot1 == rot_dec(prev_rot1)))
		else begin
			$error("ERROR t=%0t rot1 prev=%0d got=%0d", $time, prev_rot1, rot1);
			fail_cnt++;
		end

	a_rot2: assert property (@(posedge clk_53p6) disable iff (hold)
		(!cfg.ls30_en[1] && !prev_ls[1]) |-> rot2 == prev_rot2 ||
		(prev_c2.rot_left && rot2 == rot_inc(prev_rot2)) ||
		(!prev_c2.rot_left && prev_c2.rot_right && rot2 == rot_dec(prev_rot2)))
		else begin
			$error("ERROR t=%0t rot2 prev=%0d got=%0d", $time, prev_rot2, rot2);
			fail_cnt++;
		end

	a_ls30_1: assert property (@(posedge clk_53p6) disable iff (hold)
		(cfg.ls30_en[0] && prev_ls[0]) |-> rot1 == (take1 ? prev_code1 : prev_rot1))
		else begin
			$error("ERROR t=%0t rot1 exp=%0d got=%0d", $time,
				take1 ? prev_code1 : prev_rot1, rot1);
			fail_cnt++;
		end

	a_ls30_2: assert property (@(posedge clk_53p6) disable iff (hold)
		(cfg.ls30_en[1] && prev_ls[1]) |-> rot2 == (take2 ? prev_code2 : prev_rot2))
		else begin
			$error("ERROR t=%0t rot2 exp=%0d got=%0d", $time,
				take2 ? prev_code2 : prev_rot2, rot2);
			fail_cnt++;
		end

	a_dip: assert property (@(posedge clk_53p6) disable iff (hold)
		dsw1 == want_dsw1 && dsw2 == want_dsw2 && game == want_game)
		else begin
			$error("ERROR t=%0t dsw1/dsw2/game exp=%h/%h/%h got=%h/%h/%h", $time,
				want_dsw1, want_dsw2, want_game, dsw1, dsw2, game);
			fail_cnt++;
		end

endmodule

bind input_top input_checker u_input_checker (
	.clk_53p6    (clk_53p6),
	.rst         (rst),
	.cfg         (cfg),
	.host_joy0   (host_joy0),
	.host_joy1   (host_joy1),
	.joy_clk     (joy_clk),
	.joy_load    (joy_load),
	.pad_valid   (pad_valid),
	.pad1        (pad1),
	.pad2        (pad2),
	.c1          (c1),
	.c2          (c2),
	.rot1        (rot1),
	.rot2        (rot2),
	.player1     (player1),
	.player2     (player2),
	.ioctl_wr    (ioctl_wr),
	.ioctl_index (ioctl_index),
	.ioctl_addr  (ioctl_addr),
	.ioctl_dout  (ioctl_dout),
	.dsw1        (dsw1),
	.dsw2        (dsw2),
	.game        (game)
);

/* design/input_top.sv */
// Player-input front end top with a single synchronous reset and no handshakes
`timescale 1ns/1ps

module input_top #(
	parameter int JOY_DIV  = 8,
	parameter int ROT_STEP = 8388608
) (
	input  logic                   clk_53p6,
	input  logic                   rst,
	input  logic                   joy_data,
	input  snac_pkg::host_joy_t    host_joy0,
	input  snac_pkg::host_joy_t    host_joy1,
	input  snac_pkg::snac_cfg_t    cfg,
	input  logic                   ioctl_wr,
	input  logic [7:0]             ioctl_index,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	output logic                   joy_clk,
	output logic                   joy_load,
	output snac_pkg::player_word_t player1,
	output snac_pkg::player_word_t player2,
	output logic [7:0]             dsw1,
	output logic [7:0]             dsw2,
	output logic [7:0]             game
);

	// Frame end strobe, observed by the checker
	logic                   pad_valid;
	snac_pkg::pad_word_t    pad1;
	snac_pkg::pad_word_t    pad2;
	snac_pkg::player_ctrl_t c1;
	snac_pkg::player_ctrl_t c2;
	snac_pkg::rot_pos_t     rot1;
	snac_pkg::rot_pos_t     rot2;

	// ============================
	// Serial pads into mapper
	// ============================

	db15_reader #(
		.JOY_DIV (JOY_DIV)
	) u_db15_reader (
		.clk_53p6  (clk_53p6),
		.rst       (rst),
		.joy_data  (joy_data),
		.joy_clk   (joy_clk),
		.joy_load  (joy_load),
		.pad_valid (pad_valid),
		.pad1      (pad1),
		.pad2      (pad2)
	);

	control_mapper u_control_mapper (
		.clk_53p6  (clk_53p6),
		.rst       (rst),
		.cfg       (cfg),
		.host_joy0 (host_joy0),
		.host_joy1 (host_joy1),
		.pad1      (pad1),
		.pad2      (pad2),
		.rot1      (rot1),
		.rot2      (rot2),
		.c1        (c1),
		.c2        (c2),
		.player1   (player1),
		.player2   (player2)
	);

	// Position loops back into the mapper
	rotary_tracker #(
		.ROT_STEP (ROT_STEP)
	) u_rotary_tracker (
		.clk_53p6 (clk_53p6),
		.rst      (rst),
		.ls30_en  (cfg.ls30_en),
		.c1       (c1),
		.c2       (c2),
		.pad1     (pad1),
		.pad2     (pad2),
		.rot1     (rot1),
		.rot2     (rot2)
	);

	dip_bank u_dip_bank (
		.clk_53p6    (clk_53p6),
		.rst         (rst),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game        (game)
	);

endmodule

/* design/dip_bank.sv */
// DIP and game-select capture from the download stream, no read-back of bytes 2 to 7
`timescale 1ns/1ps

module dip_bank (
	input  logic        clk_53p6,
	input  logic        rst,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic [7:0]  dsw1,
	output logic [7:0]  dsw2,
	output logic [7:0]  game
);

	localparam int AW = $clog2(snac_pkg::DIP_BYTES);

	logic [7:0] dip_mem [snac_pkg::DIP_BYTES];
	logic       dip_hit;
	logic       game_hit;

	// Address decode for the two targets
	assign dip_hit  = ioctl_wr && (ioctl_index == snac_pkg::DIP_INDEX) &&
		(ioctl_addr < 25'(snac_pkg::DIP_BYTES));
	assign game_hit = ioctl_wr && (ioctl_index == snac_pkg::GAME_INDEX) &&
		(ioctl_addr == '0);

	// Switches default to all off
	always_ff @(posedge clk_53p6) begin
		if (rst) begin
			for (int i = 0; i < snac_pkg::DIP_BYTES; i++) begin
				dip_mem[i] <= '0;
			end
			game <= '0;
		end else begin
			if (dip_hit) begin
				dip_mem[ioctl_addr[AW-1:0]] <= ioctl_dout;
			end
			if (game_hit) begin
				game <= ioctl_dout;
			end
		end
	end

	// Only the first two banks reach the game
	assign dsw1 = dip_mem[0];
	assign dsw2 = dip_mem[1];

endmodule

/* design/rotary_tracker.sv */
// Twelve-position rotary counters and LS-30 follower, one step per ROT_STEP cycles
`timescale 1ns/1ps

module rotary_tracker #(
	parameter int ROT_STEP = 8388608
) (
	input  logic                   clk_53p6,
	input  logic                   rst,
	input  logic [1:0]             ls30_en,
	input  snac_pkg::player_ctrl_t c1,
	input  snac_pkg::player_ctrl_t c2,
	input  snac_pkg::pad_word_t    pad1,
	input  snac_pkg::pad_word_t    pad2,
	output snac_pkg::rot_pos_t     rot1,
	output snac_pkg::rot_pos_t     rot2
);

	localparam int DIV_W = (ROT_STEP > 1) ? $clog2(ROT_STEP) : 1;
	localparam snac_pkg::rot_pos_t ROT_MAX =
		snac_pkg::rot_pos_t'(snac_pkg::ROT_POSITIONS - 1);

	logic [DIV_W-1:0]       step_cnt;
	logic                   step_tick;
	snac_pkg::player_ctrl_t ctrl_in [2];
	snac_pkg::pad_word_t    pad_in  [2];
	snac_pkg::rot_pos_t     rot_out [2];

	assign ctrl_in[0] = c1;
	assign ctrl_in[1] = c2;
	assign pad_in[0]  = pad1;
	assign pad_in[1]  = pad2;
	assign rot1       = rot_out[0];
	assign rot2       = rot_out[1];

	// ============================
	// Step divider
	// ============================

	// Free running, shared by both players
	assign step_tick = (step_cnt == DIV_W'(ROT_STEP - 1));

	always_ff @(posedge clk_53p6) begin
		if (rst || step_tick) begin
			step_cnt <= '0;
		end else begin
			step_cnt <= step_cnt + DIV_W'(1);
		end
	end

	for (genvar p = 0; p < 2; p++) begin : g_player
		localparam snac_pkg::rot_pos_t RST_POS =
			(p == 0) ? snac_pkg::ROT_RESET_P1 : snac_pkg::ROT_RESET_P2;

		snac_pkg::rot_pos_t cnt_pos;
		snac_pkg::rot_pos_t ls_pos;
		logic [3:0]         ls_code;
		logic [3:0]         ls_prev;

		// Button counter, left wins over right
		always_ff @(posedge clk_53p6) begin
			if (rst) begin
				cnt_pos <= RST_POS;
			end else if (step_tick) begin
				if (ctrl_in[p].rot_left) begin
					cnt_pos <= (cnt_pos == ROT_MAX) ? '0 : cnt_pos + 4'd1;
				end else if (ctrl_in[p].rot_right) begin
					cnt_pos <= (cnt_pos == '0) ? ROT_MAX : cnt_pos - 4'd1;
				end
			end
		end

		// LS-30 code rides on buttons C..F
		assign ls_code = pad_in[p][9:6];

		always_ff @(posedge clk_53p6) begin
			if (rst) begin
				ls_prev <= snac_pkg::PAD_IDLE[9:6];
				ls_pos  <= ROT_MAX;
			end else begin
				ls_prev <= ls_code;
				// Codes 12 to 15 are not positions
				if (ls_code != ls_prev && ls_code < 4'(snac_pkg::ROT_POSITIONS)) begin
					ls_pos <= ls_code;
				end
			end
		end

		assign rot_out[p] = ls30_en[p] ? ls_pos : cnt_pos;
	end

endmodule

/* design/control_mapper.sv */
// Per-player source select and packing with outputs registered once and no input sync
`timescale 1ns/1ps

module control_mapper (
	input  logic                   clk_53p6,
	input  logic                   rst,
	input  snac_pkg::snac_cfg_t    cfg,
	input  snac_pkg::host_joy_t    host_joy0,
	input  snac_pkg::host_joy_t    host_joy1,
	input  snac_pkg::pad_word_t    pad1,
	input  snac_pkg::pad_word_t    pad2,
	input  snac_pkg::rot_pos_t     rot1,
	input  snac_pkg::rot_pos_t     rot2,
	output snac_pkg::player_ctrl_t c1,
	output snac_pkg::player_ctrl_t c2,
	output snac_pkg::player_word_t player1,
	output snac_pkg::player_word_t player2
);

	// Per-player views so both players share one block of logic
	snac_pkg::pad_word_t    pad_in  [2];
	snac_pkg::host_joy_t    host_in [2];
	snac_pkg::rot_pos_t     rot_in  [2];
	snac_pkg::player_ctrl_t ctrl_q  [2];
	snac_pkg::player_word_t word_q  [2];

	assign pad_in[0]  = pad1;
	assign pad_in[1]  = pad2;
	assign host_in[0] = host_joy0;
	assign host_in[1] = host_joy1;
	assign rot_in[0]  = rot1;
	assign rot_in[1]  = rot2;

	assign c1      = ctrl_q[0];
	assign c2      = ctrl_q[1];
	assign player1 = word_q[0];
	assign player2 = word_q[1];

	for (genvar p = 0; p < 2; p++) begin : g_player
		logic                   use_pad;
		snac_pkg::pad_word_t    pad_sel;
		snac_pkg::player_ctrl_t pad_ctrl;
		snac_pkg::player_ctrl_t host_ctrl;
		snac_pkg::player_ctrl_t ctrl_d;
		snac_pkg::player_word_t word_d;

		// Either SNAC mode routes the pad in
		assign use_pad = cfg.db15_en[p] | cfg.ls30_en[p];
		assign pad_sel = use_pad ? pad_in[p] : snac_pkg::PAD_IDLE;

		// ============================
		// Pad decode, bits inverted
		// ============================
		always_comb begin
			pad_ctrl.up        = ~pad_sel[3];
			pad_ctrl.down      = ~pad_sel[2];
			pad_ctrl.left      = ~pad_sel[1];
			pad_ctrl.right     = ~pad_sel[0];
			pad_ctrl.start     = ~pad_sel[10];
			// Select doubles as coin
			pad_ctrl.coin      = ~pad_sel[11];
			pad_ctrl.rot_left  = ~pad_sel[4];
			pad_ctrl.rot_right = ~pad_sel[7];
			// Select+B and Select+A chords
			pad_ctrl.service   = ~pad_sel[5] & ~pad_sel[11];
			pad_ctrl.pause     = ~pad_sel[4] & ~pad_sel[11];
			// NeoGeo style pad fires on B/C, LS-30 stick on A/B
			if (cfg.db15_en[p]) begin
				pad_ctrl.shot    = ~pad_sel[5];
				pad_ctrl.missile = ~pad_sel[6];
			end else begin
				pad_ctrl.shot    = ~pad_sel[4];
				pad_ctrl.missile = ~pad_sel[5];
			end
		end

		// Host word already active high
		always_comb begin
			host_ctrl.right     = host_in[p][0];
			host_ctrl.left      = host_in[p][1];
			host_ctrl.down      = host_in[p][2];
			host_ctrl.up        = host_in[p][3];
			host_ctrl.shot      = host_in[p][4];
			host_ctrl.missile   = host_in[p][5];
			host_ctrl.start     = host_in[p][6];
			host_ctrl.coin      = host_in[p][7];
			host_ctrl.rot_left  = host_in[p][8];
			host_ctrl.rot_right = host_in[p][9];
			host_ctrl.service   = host_in[p][10];
			host_ctrl.pause     = host_in[p][11];
		end

		assign ctrl_d = use_pad ? pad_ctrl : host_ctrl;

		// Pack active low, filler bits high
		always_comb begin
			word_d.ones    = 2'b11;
			word_d.up      = ~ctrl_d.up;
			word_d.down    = ~ctrl_d.down;
			word_d.right   = ~ctrl_d.right;
			word_d.left    = ~ctrl_d.left;
			word_d.service = ~ctrl_d.service;
			word_d.one     = 1'b1;
			word_d.rot     = rot_in[p];
			word_d.missile = ~ctrl_d.missile;
			word_d.shot    = ~ctrl_d.shot;
			word_d.start   = ~ctrl_d.start;
			word_d.coin    = ~ctrl_d.coin;
		end

		always_ff @(posedge clk_53p6) begin
			if (rst) begin
				ctrl_q[p] <= '0;
				word_q[p] <= '1;
			end else begin
				ctrl_q[p] <= ctrl_d;
				word_q[p] <= word_d;
			end
		end
	end

endmodule

/* design/db15_reader.sv */
// Two-pad DB15 serial reader with no synchronizer on joy_data and a fixed 32-bit frame
`timescale 1ns/1ps

module db15_reader #(
	parameter int JOY_DIV = 8
) (
	input  logic                clk_53p6,
	input  logic                rst,
	input  logic                joy_data,
	output logic                joy_clk,
	output logic                joy_load,
	output logic                pad_valid,
	output snac_pkg::pad_word_t pad1,
	output snac_pkg::pad_word_t pad2
);

	localparam int DIV_W = (JOY_DIV > 1) ? $clog2(JOY_DIV) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SHIFT
	} rd_state_t;

	rd_state_t        state;
	logic [DIV_W-1:0] div_cnt;
	logic             half_tick;
	logic             load_half;
	logic [4:0]       bit_cnt;
	logic [31:0]      shift_sr;

	// One half period of the serial clock
	assign half_tick = (div_cnt == DIV_W'(JOY_DIV - 1));

	// ============================
	// Frame sequencer
	// ============================

	always_ff @(posedge clk_53p6) begin
		if (rst) begin
			state     <= ST_IDLE;
			div_cnt   <= '0;
			load_half <= 1'b0;
			bit_cnt   <= '0;
			joy_clk   <= 1'b0;
			joy_load  <= 1'b0;
			pad_valid <= 1'b0;
			pad1      <= snac_pkg::PAD_IDLE;
			pad2      <= snac_pkg::PAD_IDLE;
		end else begin
			pad_valid <= 1'b0;

			// Divider held at zero until the first load
			if (state == ST_IDLE || half_tick) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + DIV_W'(1);
			end

			case (state)
				ST_IDLE: begin
					joy_load  <= 1'b1;
					load_half <= 1'b0;
					state     <= ST_LOAD;
				end
				// Load stays high for a full bit period
				ST_LOAD: begin
					if (half_tick) begin
						load_half <= ~load_half;
						if (load_half) begin
							joy_load <= 1'b0;
							bit_cnt  <= '0;
							state    <= ST_SHIFT;
						end
					end
				end
				ST_SHIFT: begin
					if (half_tick) begin
						joy_clk <= ~joy_clk;
						// Falling edge closes a bit
						if (joy_clk) begin
							bit_cnt <= bit_cnt + 5'd1;
							if (bit_cnt == 5'd31) begin
								pad1      <= shift_sr[31:16];
								pad2      <= shift_sr[15:0];
								pad_valid <= 1'b1;
								// Next frame starts right away
								joy_load  <= 1'b1;
								load_half <= 1'b0;
								state     <= ST_LOAD;
							end
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Sample on the rising edge, pad 1 bit 15 arrives first
	always_ff @(posedge clk_53p6) begin
		if (state == ST_SHIFT && half_tick && !joy_clk) begin
			shift_sr <= {shift_sr[30:0], joy_data};
		end
	end

endmodule

/* design/snac_pkg.sv */
// Shared input types and constants. Pad words are active low, host words active high
package snac_pkg;

	// ============================
	// Raw input words
	// ============================

	// DB15 pad as shifted in, bit 0 R up to bit 11 Select, upper nibble unused
	typedef logic [15:0] pad_word_t;

	// Host joystick word, right/left/down/up then buttons from bit 4
	typedef logic [15:0] host_joy_t;

	// Rotary position, 0 to 11
	typedef logic [3:0] rot_pos_t;

	// Per-player enables from the core menu
	typedef struct packed {
		logic [1:0] db15_en;
		logic [1:0] ls30_en;
	} snac_cfg_t;

	// ============================
	// Decoded and packed words
	// ============================

	// Presses after source selection, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic shot;
		logic missile;
		logic start;
		logic coin;
		logic service;
		logic pause;
		logic rot_left;
		logic rot_right;
	} player_ctrl_t;

	// Control word seen by the game, active low, MSB first
	typedef struct packed {
		logic [1:0] ones;
		logic       up;
		logic       down;
		logic       right;
		logic       left;
		logic       service;
		logic       one;
		rot_pos_t   rot;
		logic       missile;
		logic       shot;
		logic       start;
		logic       coin;
	} player_word_t;

	// ============================
	// Constants
	// ============================

	localparam int ROT_POSITIONS = 12;

	// Player 1 starts one position left of player 2
	localparam rot_pos_t ROT_RESET_P1 = 4'd11;
	localparam rot_pos_t ROT_RESET_P2 = 4'd0;

	// Download stream indexes
	localparam logic [7:0] DIP_INDEX  = 8'd254;
	localparam logic [7:0] GAME_INDEX = 8'd1;

	localparam int DIP_BYTES = 8;

	// Nothing pressed
	localparam pad_word_t PAD_IDLE = 16'hffff;

endpackage
